// ==== verilog.f ====
src/analog_pkg.sv
src/cal_cfg_if.sv
src/calib_regs.sv
src/linear_cal.sv
src/channel_path.sv
src/dac_interleave.sv
src/analog_top.sv
verification/clk_rst_gen.sv
verification/analog_top_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f \
  --top-module analog_top_tb --Mdir obj_dir -o analog_top_tb

./obj_dir/analog_top_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Result: PASSED" sim.log; then
  exit 0
else
  exit 1
fi

// ==== verification/analog_top_tb.sv ====
`timescale 1ns/10ps

module analog_top_tb;

  localparam int ROWS = 15;
  localparam int CLK_NS = 100;
  // ten cycles per row plus margin for reset
  localparam int LIMIT_NS = (ROWS * 10 + 20) * CLK_NS;

  logic                             adc_clk;
  logic                             top_rst;
  logic [analog_pkg::ADC_RAW_W-1:0] adc0_dat;
  logic [analog_pkg::ADC_RAW_W-1:0] adc1_dat;
  analog_pkg::sample_t              asg0_dat;
  analog_pkg::sample_t              asg1_dat;
  logic                             dig_loop;
  logic                             cal_wr;
  logic                             cal_chan;
  logic                             cal_dac;
  analog_pkg::mul_t                 cal_mul;
  analog_pkg::sum_t                 cal_sum;
  analog_pkg::sample_t              osc0_dat;
  analog_pkg::sample_t              osc1_dat;
  logic [analog_pkg::SMP_W-1:0]     dac_dat;
  logic                             dac_sel;
  logic                             dac_wrt;
  logic                             dac_rst;

  // stimulus table with one entry per row
  string                        row_name [ROWS];
  bit                           row_wr   [ROWS];
  bit                           row_chan [ROWS];
  bit                           row_dac  [ROWS];
  analog_pkg::mul_t             row_mul  [ROWS];
  analog_pkg::sum_t             row_sum  [ROWS];
  logic [15:0]                  row_adc0 [ROWS];
  logic [15:0]                  row_adc1 [ROWS];
  analog_pkg::sample_t          row_asg0 [ROWS];
  analog_pkg::sample_t          row_asg1 [ROWS];
  bit                           row_loop [ROWS];
  bit                           row_rnd  [ROWS];
  int                           n_rows;
  int                           err_cnt;

  // model copy of the coefficients
  analog_pkg::mul_t             mdl_adc_mul [2];
  analog_pkg::sum_t             mdl_adc_sum [2];
  analog_pkg::mul_t             mdl_dac_mul [2];
  analog_pkg::sum_t             mdl_dac_sum [2];

  clk_rst_gen u_clk (
    .clk_o (adc_clk),
    .rst_o (top_rst)
  );

  analog_top dut0 (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .adc0_dat_i     (adc0_dat),
    .adc1_dat_i     (adc1_dat),
    .asg0_dat_i     (asg0_dat),
    .asg1_dat_i     (asg1_dat),
    .digital_loop_i (dig_loop),
    .cal_wr_i       (cal_wr),
    .cal_chan_i     (cal_chan),
    .cal_dac_i      (cal_dac),
    .cal_mul_i      (cal_mul),
    .cal_sum_i      (cal_sum),
    .osc0_dat_o     (osc0_dat),
    .osc1_dat_o     (osc1_dat),
    .dac_dat_o      (dac_dat),
    .dac_sel_o      (dac_sel),
    .dac_wrt_o      (dac_wrt),
    .dac_rst_o      (dac_rst)
  );

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // sign of bits 15..2 kept and the rest inverted
  function automatic analog_pkg::sample_t capture_word(input logic [15:0] raw);
    analog_pkg::sample_t v;
    v[13] = raw[15];
    v[12:0] = ~raw[14:2];
    return v;
  endfunction

  // x * gain / 2^14 + offset and then clip
  function automatic analog_pkg::sample_t calibrate(input analog_pkg::sample_t x,
                                                    input analog_pkg::mul_t g,
                                                    input analog_pkg::sum_t o);
    longint total;
    total = ((longint'(x) * longint'(g)) >>> analog_pkg::MUL_FRAC) + longint'(o);
    if (total > longint'(analog_pkg::SMP_MAX)) begin
      return analog_pkg::SMP_MAX;
    end
    if (total < longint'(analog_pkg::SMP_MIN)) begin
      return analog_pkg::SMP_MIN;
    end
    return analog_pkg::sample_t'(total);
  endfunction

  // inverted offset binary
  function automatic logic [13:0] dac_code(input analog_pkg::sample_t s);
    return {s[13], ~s[12:0]};
  endfunction

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // four state compare so an unknown output is caught
  task automatic check_value(input string what, input logic signed [31:0] expected,
                             input logic signed [31:0] actual);
    if (expected !== actual) begin
      err_cnt++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", what, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // inputs change 10 ns after the edge
  task automatic next_edge();
    @(posedge adc_clk);
    #10;
  endtask

  task automatic add_row(input string name, input int wr, input int chan, input int dac,
                         input int mul, input int sum, input int adc0, input int adc1,
                         input int asg0, input int asg1, input int loop, input int rnd);
    row_name[n_rows] = name;
    row_wr[n_rows]   = wr[0];
    row_chan[n_rows] = chan[0];
    row_dac[n_rows]  = dac[0];
    row_mul[n_rows]  = analog_pkg::mul_t'(mul);
    row_sum[n_rows]  = analog_pkg::sum_t'(sum);
    row_adc0[n_rows] = adc0[15:0];
    row_adc1[n_rows] = adc1[15:0];
    row_asg0[n_rows] = analog_pkg::sample_t'(asg0);
    row_asg1[n_rows] = analog_pkg::sample_t'(asg1);
    row_loop[n_rows] = loop[0];
    row_rnd[n_rows]  = rnd[0];
    n_rows++;
  endtask

  task automatic load_table();
    //      name           wr ch dac mul    sum    adc0     adc1     asg0   asg1   lp rnd
    add_row("dflt_pos",    0, 0, 0,  0,     0,     'h1234, 'h0ab8, 100,   -200,  0, 0);
    add_row("dflt_neg",    0, 0, 0,  0,     0,     'hc3f0, 'hfffc, 0,     0,     0, 0);
    add_row("adc0_half",   1, 0, 0,  8192,  100,   'h2468, 'h2468, 0,     0,     0, 0);
    add_row("adc0_sat_hi", 1, 0, 0,  32767, 50,    'h0000, 'h0000, 0,     0,     0, 0);
    add_row("adc0_sat_lo", 1, 0, 0,  32767, -50,   'hfffc, 'hfffc, 0,     0,     0, 0);
    add_row("adc1_ofs",    1, 1, 0,  12288, -500,  'h5550, 'h5550, 0,     0,     0, 0);
    add_row("adc0_unity",  1, 0, 0,  16384, 0,     'h7000, 'h9000, 0,     0,     0, 0);
    add_row("dac0_cal",    1, 0, 1,  8192,  300,   'h1000, 'h1000, 4000,  -3000, 0, 0);
    add_row("dac1_cal",    1, 1, 1,  20000, -1000, 'h1000, 'h1000, -5000, 6000,  0, 0);
    add_row("loop_pos",    0, 0, 0,  0,     0,     'h4444, 'h8888, 1234,  2345,  1, 0);
    add_row("loop_neg",    0, 0, 0,  0,     0,     'h0000, 'hfffc, -8000, -7000, 1, 0);
    add_row("rnd_a",       0, 0, 0,  0,     0,     0,      0,      0,     0,     0, 1);
    add_row("rnd_b",       0, 0, 0,  0,     0,     0,      0,      0,     0,     0, 1);
    add_row("rnd_c",       0, 0, 0,  0,     0,     0,      0,      0,     0,     0, 1);
    add_row("loop_off",    0, 0, 0,  0,     0,     'h3ffc, 'hc000, 0,     0,     0, 0);
  endtask

  // random write and random inputs
  task automatic randomize_row(input int i);
    row_wr[i]   = 1'b1;
    row_chan[i] = 1'($urandom);
    row_dac[i]  = 1'($urandom);
    row_mul[i]  = analog_pkg::mul_t'($urandom);
    row_sum[i]  = analog_pkg::sum_t'($urandom);
    row_adc0[i] = 16'($urandom);
    row_adc1[i] = 16'($urandom);
    row_asg0[i] = analog_pkg::sample_t'($urandom);
    row_asg1[i] = analog_pkg::sample_t'($urandom);
    row_loop[i] = 1'($urandom);
  endtask

  task automatic model_write(input int i);
    if (row_dac[i]) begin
      mdl_dac_mul[row_chan[i]] = row_mul[i];
      mdl_dac_sum[row_chan[i]] = row_sum[i];
    end else begin
      mdl_adc_mul[row_chan[i]] = row_mul[i];
      mdl_adc_sum[row_chan[i]] = row_sum[i];
    end
  endtask

  ////////////////////////////////////////
  // test sequences
  ////////////////////////////////////////

  task automatic reset_sequence();
    logic exp_sel;
    @(negedge adc_clk);
    check_value("reset dac_rst_o", 1, dac_rst);
    check_value("reset dac_wrt_o", 0, dac_wrt);
    check_value("reset dac_sel_o", 0, dac_sel);
    check_value("reset dac_dat_o", 0, dac_dat);
    @(negedge top_rst);
    @(posedge adc_clk);
    @(negedge adc_clk);
    check_value("release dac_rst_o", 0, dac_rst);
    check_value("release dac_wrt_o", 1, dac_wrt);
    // phase leaves reset at 0 and flips on the first edge
    exp_sel = 1'b1;
    check_value("release dac_sel_o", exp_sel, dac_sel);
    repeat (3) begin
      @(negedge adc_clk);
      exp_sel = !exp_sel;
      check_value("release dac_sel_o", exp_sel, dac_sel);
    end
  endtask

  task automatic run_row(input int i);
    analog_pkg::sample_t dac0;
    analog_pkg::sample_t dac1;
    analog_pkg::sample_t exp_osc0;
    analog_pkg::sample_t exp_osc1;
    if (row_rnd[i]) begin
      randomize_row(i);
    end
    next_edge();
    if (row_wr[i]) begin
      // one cycle write strobe
      cal_wr   = 1'b1;
      cal_chan = row_chan[i];
      cal_dac  = row_dac[i];
      cal_mul  = row_mul[i];
      cal_sum  = row_sum[i];
      model_write(i);
      next_edge();
      cal_wr   = 1'b0;
    end
    adc0_dat = row_adc0[i];
    adc1_dat = row_adc1[i];
    asg0_dat = row_asg0[i];
    asg1_dat = row_asg1[i];
    dig_loop = row_loop[i];
    // expected values from the model
    dac0 = calibrate(row_asg0[i], mdl_dac_mul[0], mdl_dac_sum[0]);
    dac1 = calibrate(row_asg1[i], mdl_dac_mul[1], mdl_dac_sum[1]);
    exp_osc0 = calibrate(row_loop[i] ? dac0 : capture_word(row_adc0[i]),
                         mdl_adc_mul[0], mdl_adc_sum[0]);
    exp_osc1 = calibrate(row_loop[i] ? dac1 : capture_word(row_adc1[i]),
                         mdl_adc_mul[1], mdl_adc_sum[1]);
    repeat (6) @(posedge adc_clk);
    // last two cycles cover both bus phases
    repeat (2) begin
      @(posedge adc_clk);
      @(negedge adc_clk);
      check_value($sformatf("%s osc0", row_name[i]), exp_osc0, osc0_dat);
      check_value($sformatf("%s osc1", row_name[i]), exp_osc1, osc1_dat);
      if (dac_sel) begin
        check_value($sformatf("%s code0", row_name[i]), dac_code(dac0), dac_dat);
      end else begin
        check_value($sformatf("%s code1", row_name[i]), dac_code(dac1), dac_dat);
      end
    end
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    void'($urandom(35));
    adc0_dat = '0;
    adc1_dat = '0;
    asg0_dat = '0;
    asg1_dat = '0;
    dig_loop = 1'b0;
    cal_wr   = 1'b0;
    cal_chan = 1'b0;
    cal_dac  = 1'b0;
    cal_mul  = '0;
    cal_sum  = '0;
    n_rows   = 0;
    err_cnt  = 0;
    for (int c = 0; c < 2; c++) begin
      mdl_adc_mul[c] = analog_pkg::MUL_UNITY;
      mdl_adc_sum[c] = analog_pkg::SUM_RESET;
      mdl_dac_mul[c] = analog_pkg::MUL_UNITY;
      mdl_dac_sum[c] = analog_pkg::SUM_RESET;
    end
    load_table();
    reset_sequence();
    for (int i = 0; i < n_rows; i++) begin
      run_row(i);
    end
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(LIMIT_NS);
    $display("timeout: the tests did not finish within %0d ns", LIMIT_NS);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule : analog_top_tb

// ==== verification/clk_rst_gen.sv ====
`timescale 1ns/10ps

module clk_rst_gen (
  output logic clk_o,
  output logic rst_o
);

  // 100 ns clock period
  localparam int HALF_NS = 50;
  // cycles of reset after start
  localparam int RST_CYC = 4;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_NS) clk_o = ~clk_o;
    end
  end

  // release a little after the edge
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYC) @(posedge clk_o);
    #10 rst_o = 1'b0;
  end

endmodule : clk_rst_gen

// ==== src/analog_top.sv ====
`timescale 1ns/10ps

module analog_top (
  input  logic                             adc_clk,
  input  logic                             top_rst,
  // adc converter words
  input  logic [analog_pkg::ADC_RAW_W-1:0] adc0_dat_i,
  input  logic [analog_pkg::ADC_RAW_W-1:0] adc1_dat_i,
  // generator samples
  input  analog_pkg::sample_t              asg0_dat_i,
  input  analog_pkg::sample_t              asg1_dat_i,
  // loopback level
  input  logic                             digital_loop_i,
  // coefficient write
  input  logic                             cal_wr_i,
  input  logic                             cal_chan_i,
  input  logic                             cal_dac_i,
  input  analog_pkg::mul_t                 cal_mul_i,
  input  analog_pkg::sum_t                 cal_sum_i,
  // calibrated adc samples
  output analog_pkg::sample_t              osc0_dat_o,
  output analog_pkg::sample_t              osc1_dat_o,
  // combined dac bus
  output logic [analog_pkg::SMP_W-1:0]     dac_dat_o,
  output logic                             dac_sel_o,
  output logic                             dac_wrt_o,
  output logic                             dac_rst_o
);

  // calibrated dac samples per channel
  analog_pkg::sample_t dac0_smp;
  analog_pkg::sample_t dac1_smp;

  // coefficients per channel
  cal_cfg_if cfg0 ();
  cal_cfg_if cfg1 ();

  ////////////////////////////////////////
  // calibration registers
  ////////////////////////////////////////

  calib_regs u_calib (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .cal_wr_i   (cal_wr_i),
    .cal_chan_i (cal_chan_i),
    .cal_dac_i  (cal_dac_i),
    .cal_mul_i  (cal_mul_i),
    .cal_sum_i  (cal_sum_i),
    .cfg0       (cfg0),
    .cfg1       (cfg1)
  );

  ////////////////////////////////////////
  // channel datapaths
  ////////////////////////////////////////

  // channel 0
  channel_path u_ch0 (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .adc_dat_i      (adc0_dat_i),
    .asg_dat_i      (asg0_dat_i),
    .digital_loop_i (digital_loop_i),
    .cfg            (cfg0),
    .osc_dat_o      (osc0_dat_o),
    .dac_smp_o      (dac0_smp)
  );

  // channel 1
  channel_path u_ch1 (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .adc_dat_i      (adc1_dat_i),
    .asg_dat_i      (asg1_dat_i),
    .digital_loop_i (digital_loop_i),
    .cfg            (cfg1),
    .osc_dat_o      (osc1_dat_o),
    .dac_smp_o      (dac1_smp)
  );

  ////////////////////////////////////////
  // dac bus
  ////////////////////////////////////////

  dac_interleave u_dac (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .dac0_smp_i (dac0_smp),
    .dac1_smp_i (dac1_smp),
    .dac_dat_o  (dac_dat_o),
    .dac_sel_o  (dac_sel_o),
    .dac_wrt_o  (dac_wrt_o),
    .dac_rst_o  (dac_rst_o)
  );

endmodule : analog_top

// ==== src/dac_interleave.sv ====
`timescale 1ns/10ps

module dac_interleave (
  input  logic                          adc_clk,
  input  logic                          top_rst,
  // calibrated samples of both channels
  input  analog_pkg::sample_t           dac0_smp_i,
  input  analog_pkg::sample_t           dac1_smp_i,
  // combined dac bus
  output logic [analog_pkg::SMP_W-1:0]  dac_dat_o,
  output logic                          dac_sel_o,
  output logic                          dac_wrt_o,
  output logic                          dac_rst_o
);

  // offset binary codes, negative slope
  logic [analog_pkg::SMP_W-1:0] code0;
  logic [analog_pkg::SMP_W-1:0] code1;
  // registered codes
  logic [analog_pkg::SMP_W-1:0] code0_r;
  logic [analog_pkg::SMP_W-1:0] code1_r;
  // channel phase, high selects channel 0
  logic                         sel_r;
  // dac control levels
  logic                         rst_r;
  logic                         wrt_r;

  // sign bit kept, magnitude bits inverted
  assign code0 = {dac0_smp_i[analog_pkg::SMP_W-1], ~dac0_smp_i[analog_pkg::SMP_W-2:0]};
  assign code1 = {dac1_smp_i[analog_pkg::SMP_W-1], ~dac1_smp_i[analog_pkg::SMP_W-2:0]};

  ////////////////////////////////////////
  // code and control registers
  ////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      code0_r <= '0;
      code1_r <= '0;
      sel_r   <= 1'b0;
      rst_r   <= 1'b1;
      wrt_r   <= 1'b0;
    end else begin
      code0_r <= code0;
      code1_r <= code1;
      // alternate channels every cycle
      sel_r   <= ~sel_r;
      // dac out of reset, writes enabled
      rst_r   <= 1'b0;
      wrt_r   <= 1'b1;
    end
  end

  // bus mux follows the phase
  assign dac_dat_o = sel_r ? code0_r : code1_r;
  assign dac_sel_o = sel_r;
  assign dac_wrt_o = wrt_r;
  assign dac_rst_o = rst_r;

endmodule : dac_interleave

// ==== src/channel_path.sv ====
`timescale 1ns/10ps

module channel_path (
  input  logic                                adc_clk,
  input  logic                                top_rst,
  // raw converter word
  input  logic [analog_pkg::ADC_RAW_W-1:0]    adc_dat_i,
  // generator sample
  input  analog_pkg::sample_t                 asg_dat_i,
  // loopback level
  input  logic                                digital_loop_i,
  // calibration coefficients
  cal_cfg_if.path                             cfg,
  // calibrated adc sample
  output analog_pkg::sample_t                 osc_dat_o,
  // calibrated dac sample
  output analog_pkg::sample_t                 dac_smp_o
);

  // captured, sign converted adc sample
  analog_pkg::sample_t adc_smp_r;
  // adc calibrator input after loopback mux
  analog_pkg::sample_t adc_cal_in;

  ////////////////////////////////////////
  // adc capture
  ////////////////////////////////////////

  // lowest two bits reserved
  // msb kept, rest inverted gives two's complement
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      adc_smp_r <= '0;
    end else begin
      adc_smp_r <= {adc_dat_i[analog_pkg::ADC_RAW_W-1],
                    ~adc_dat_i[analog_pkg::ADC_RAW_W-2:
                               analog_pkg::ADC_RAW_W-analog_pkg::SMP_W]};
    end
  end

  // digital loopback mux
  // own calibrated dac sample replaces the converter
  assign adc_cal_in = digital_loop_i ? dac_smp_o : adc_smp_r;

  ////////////////////////////////////////
  // calibration stages
  ////////////////////////////////////////

  // adc side, 2 cycles
  linear_cal u_adc_cal (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .smp_i   (adc_cal_in),
    .mul_i   (cfg.adc_mul),
    .sum_i   (cfg.adc_sum),
    .smp_o   (osc_dat_o)
  );

  // dac side, 2 cycles
  linear_cal u_dac_cal (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .smp_i   (asg_dat_i),
    .mul_i   (cfg.dac_mul),
    .sum_i   (cfg.dac_sum),
    .smp_o   (dac_smp_o)
  );

endmodule : channel_path

// ==== src/linear_cal.sv ====
`timescale 1ns/10ps

module linear_cal (
  input  logic                adc_clk,
  input  logic                top_rst,
  // sample in
  input  analog_pkg::sample_t smp_i,
  // gain and offset
  input  analog_pkg::mul_t    mul_i,
  input  analog_pkg::sum_t    sum_i,
  // calibrated sample out
  output analog_pkg::sample_t smp_o
);

  // stage 1, full precision product
  logic signed [analog_pkg::PRD_W-1:0] prd_r;
  // product with fraction bits dropped
  logic signed [analog_pkg::SCL_W-1:0] prd_scl;
  // scaled product plus offset
  logic signed [analog_pkg::ACC_W-1:0] acc;
  // saturated sum
  analog_pkg::sample_t                 sat;
  // stage 2 register
  analog_pkg::sample_t                 smp_r;

  ////////////////////////////////////////
  // stage 1, multiply
  ////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      prd_r <= '0;
    end else begin
      prd_r <= smp_i * mul_i;
    end
  end

  ////////////////////////////////////////
  // stage 2, offset and saturation
  ////////////////////////////////////////

  // arithmetic shift by MUL_FRAC
  assign prd_scl = prd_r[analog_pkg::PRD_W-1:analog_pkg::MUL_FRAC];
  // both sign extended to ACC_W
  assign acc = prd_scl + sum_i;

  // clip to sample range
  always_comb begin
    if (acc > analog_pkg::SMP_MAX) begin
      sat = analog_pkg::SMP_MAX;
    end else if (acc < analog_pkg::SMP_MIN) begin
      sat = analog_pkg::SMP_MIN;
    end else begin
      sat = acc[analog_pkg::SMP_W-1:0];
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      smp_r <= '0;
    end else begin
      smp_r <= sat;
    end
  end

  assign smp_o = smp_r;

endmodule : linear_cal

// ==== src/calib_regs.sv ====
`timescale 1ns/10ps

module calib_regs (
  input  logic             adc_clk,
  input  logic             top_rst,
  // write port
  input  logic             cal_wr_i,
  input  logic             cal_chan_i,
  input  logic             cal_dac_i,
  input  analog_pkg::mul_t cal_mul_i,
  input  analog_pkg::sum_t cal_sum_i,
  // coefficients per channel
  cal_cfg_if.regs          cfg0,
  cal_cfg_if.regs          cfg1
);

  ////////////////////////////////////////
  // coefficient storage
  ////////////////////////////////////////

  // adc gain/offset per channel
  analog_pkg::mul_t adc_mul_r [analog_pkg::CHN_NUM];
  analog_pkg::sum_t adc_sum_r [analog_pkg::CHN_NUM];
  // dac gain/offset per channel
  analog_pkg::mul_t dac_mul_r [analog_pkg::CHN_NUM];
  analog_pkg::sum_t dac_sum_r [analog_pkg::CHN_NUM];

  // strobe selects one gain/offset pair
  // new value visible the cycle after the strobe
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      for (int i = 0; i < analog_pkg::CHN_NUM; i++) begin
        adc_mul_r[i] <= analog_pkg::MUL_UNITY;
        adc_sum_r[i] <= analog_pkg::SUM_RESET;
        dac_mul_r[i] <= analog_pkg::MUL_UNITY;
        dac_sum_r[i] <= analog_pkg::SUM_RESET;
      end
    end else if (cal_wr_i) begin
      if (cal_dac_i) begin
        // dac direction
        dac_mul_r[cal_chan_i] <= cal_mul_i;
        dac_sum_r[cal_chan_i] <= cal_sum_i;
      end else begin
        // adc direction
        adc_mul_r[cal_chan_i] <= cal_mul_i;
        adc_sum_r[cal_chan_i] <= cal_sum_i;
      end
    end
  end

  ////////////////////////////////////////
  // outputs to channel paths
  ////////////////////////////////////////

  // channel 0
  assign cfg0.adc_mul = adc_mul_r[0];
  assign cfg0.adc_sum = adc_sum_r[0];
  assign cfg0.dac_mul = dac_mul_r[0];
  assign cfg0.dac_sum = dac_sum_r[0];

  // channel 1
  assign cfg1.adc_mul = adc_mul_r[1];
  assign cfg1.adc_sum = adc_sum_r[1];
  assign cfg1.dac_mul = dac_mul_r[1];
  assign cfg1.dac_sum = dac_sum_r[1];

endmodule : calib_regs

// ==== src/cal_cfg_if.sv ====
`timescale 1ns/10ps

// per channel calibration coefficients
// plain levels, no handshake
interface cal_cfg_if ();

  // adc side gain and offset
  analog_pkg::mul_t adc_mul;
  analog_pkg::sum_t adc_sum;

  // dac side gain and offset
  analog_pkg::mul_t dac_mul;
  analog_pkg::sum_t dac_sum;

  // register file side
  modport regs (
    output adc_mul,
    output adc_sum,
    output dac_mul,
    output dac_sum
  );

  // channel datapath side
  modport path (
    input  adc_mul,
    input  adc_sum,
    input  dac_mul,
    input  dac_sum
  );

endinterface : cal_cfg_if

// ==== src/analog_pkg.sv ====
package analog_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // raw converter word, two reserved lsbs
  localparam int unsigned ADC_RAW_W = 16;
  // useful sample bits
  localparam int unsigned SMP_W = 14;
  // gain coefficient width
  localparam int unsigned MUL_W = 16;
  // fractional bits of the gain
  localparam int unsigned MUL_FRAC = 14;
  // number of analog channels
  localparam int unsigned CHN_NUM = 2;

  // full product of sample and gain
  localparam int unsigned PRD_W = SMP_W + MUL_W;
  // product after dropping fraction bits
  localparam int unsigned SCL_W = PRD_W - MUL_FRAC;
  // offset sum, one guard bit
  localparam int unsigned ACC_W = SCL_W + 1;

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  // calibrated sample, two's complement
  typedef logic signed [SMP_W-1:0] sample_t;
  // gain, read as fraction
  typedef logic signed [MUL_W-1:0] mul_t;
  // offset, same scale as a sample
  typedef logic signed [SMP_W-1:0] sum_t;

  // saturation limits
  localparam sample_t SMP_MAX = {1'b0, {(SMP_W-1){1'b1}}};
  localparam sample_t SMP_MIN = {1'b1, {(SMP_W-1){1'b0}}};

  // reset defaults, unity gain and no offset
  localparam mul_t MUL_UNITY = mul_t'(2**MUL_FRAC);
  localparam sum_t SUM_RESET = '0;

endpackage : analog_pkg
